//--- hdl/gpio_pkg.sv
// byte type, version constant and register group enum for the gpio peripheral
package gpio_pkg;

    // one byte on the register bus
    typedef logic [7:0] byte_t;

    // returned at offset 0
    localparam byte_t GPIO_VERSION = 8'd0;

    // register group that an offset falls in
    //   0                      version / soft reset
    //   1 .. n                 input bytes
    //   n+1 .. 2n              output bytes
    //   2n+1 .. 3n             direction bytes
    typedef enum logic [2:0] {
        sel_version,
        sel_input,
        sel_output,
        sel_direction,
        sel_none
    } reg_sel_e;

endpackage : gpio_pkg

//--- hdl/ip_bus_if.sv
// decoded ip-side register bus between the address decoder and the register core
`timescale 1ns/10ps

interface ip_bus_if #(
    parameter int unsigned ABUSWIDTH = 16
);
    import gpio_pkg::*;

    // strobes gated by the address window
    logic                 rd;
    logic                 wr;
    // offset from the base address
    logic [ABUSWIDTH-1:0] add;
    byte_t                wdata;
    // registered read data from the core
    byte_t                rdata;

    modport decoder (
        output rd,
        output wr,
        output add,
        output wdata,
        input  rdata
    );

    modport core (
        input  rd,
        input  wr,
        input  add,
        input  wdata,
        output rdata
    );

endinterface : ip_bus_if

//--- hdl/bus_to_ip.sv
// address window decoder with strobe gating and read data masking
`timescale 1ns/10ps

module bus_to_ip #(
    parameter int unsigned          ABUSWIDTH = 16,
    parameter logic [ABUSWIDTH-1:0] BASEADDR  = '0,
    parameter logic [ABUSWIDTH-1:0] HIGHADDR  = '0
) (
    input  logic                 BUS_CLK,
    input  logic                 RST,
    input  logic [ABUSWIDTH-1:0] bus_add,
    input  gpio_pkg::byte_t      bus_wdata,
    input  logic                 bus_rd,
    input  logic                 bus_wr,
    input  gpio_pkg::byte_t      bus_rdata_ip,
    output gpio_pkg::byte_t      bus_rdata,
    ip_bus_if.decoder            ip
);
    import gpio_pkg::*;

    logic in_window;
    // last read landed inside the window
    logic rd_hit_q;

    assign in_window = (bus_add >= BASEADDR) && (bus_add <= HIGHADDR);

    assign ip.rd    = bus_rd && in_window;
    assign ip.wr    = bus_wr && in_window;
    assign ip.add   = bus_add - BASEADDR;
    assign ip.wdata = bus_wdata;

    // flag follows the read data latency of the core
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            rd_hit_q <= 1'b0;
        end else if (bus_rd) begin
            rd_hit_q <= in_window;
        end
    end

    // core data only for reads that hit the window
    assign bus_rdata = rd_hit_q ? bus_rdata_ip : byte_t'(0);

    // master never strobes read and write in the same cycle
    a_rd_wr_exclusive : assert property (
        @(posedge BUS_CLK) disable iff (RST) !(bus_rd && bus_wr)
    ) else $error("bus_rd and bus_wr high together");

endmodule : bus_to_ip

//--- hdl/gpio_regs.sv
// register bank with version, input, output and direction bytes, soft reset and read mux
`timescale 1ns/10ps

module gpio_regs #(
    parameter int unsigned IO_WIDTH = 8
) (
    input  logic                BUS_CLK,
    input  logic                RST,
    input  logic [IO_WIDTH-1:0] input_bits,
    output logic [IO_WIDTH-1:0] output_bits,
    output logic [IO_WIDTH-1:0] direction_bits,
    ip_bus_if.core              ip
);
    import gpio_pkg::*;

    // bytes per register group
    localparam int unsigned io_bytes = (IO_WIDTH + 7) / 8;
    localparam int unsigned idx_w    = (io_bytes > 1) ? $clog2(io_bytes) : 1;

    byte_t                 out_q [io_bytes];
    byte_t                 dir_q [io_bytes];
    byte_t                 rdata_q;
    logic [io_bytes*8-1:0] in_pad;
    int unsigned           off;
    reg_sel_e              sel;
    logic [idx_w-1:0]      idx;
    logic                  soft_rst;

    assign off = 32'(ip.add);

    // group and byte index within the group
    always_comb begin
        sel = sel_none;
        idx = '0;
        if (off == 0) begin
            sel = sel_version;
        end else if (off <= io_bytes) begin
            sel = sel_input;
            idx = idx_w'(off - 1);
        end else if (off <= 2 * io_bytes) begin
            sel = sel_output;
            idx = idx_w'(off - (io_bytes + 1));
        end else if (off <= 3 * io_bytes) begin
            sel = sel_direction;
            idx = idx_w'(off - (2 * io_bytes + 1));
        end
    end

    // top byte padded with zeros above IO_WIDTH
    always_comb begin
        in_pad = '0;
        in_pad[IO_WIDTH-1:0] = input_bits;
    end

    // write to offset 0
    assign soft_rst = ip.wr && (sel == sel_version);

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst) begin
            for (int b = 0; b < io_bytes; b++) begin
                out_q[b] <= '0;
                dir_q[b] <= '0;
            end
        end else if (ip.wr) begin
            case (sel)
                sel_output:    out_q[idx] <= ip.wdata;
                sel_direction: dir_q[idx] <= ip.wdata;
                // input bytes are read only
                default: ;
            endcase
        end
    end

    // read data held until the next read
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            rdata_q <= '0;
        end else if (ip.rd) begin
            case (sel)
                sel_version:   rdata_q <= GPIO_VERSION;
                sel_input:     rdata_q <= in_pad[idx*8 +: 8];
                sel_output:    rdata_q <= out_q[idx];
                sel_direction: rdata_q <= dir_q[idx];
                default:       rdata_q <= '0;
            endcase
        end
    end

    assign ip.rdata = rdata_q;

    // flatten byte arrays onto the pin vectors
    for (genvar i = 0; i < IO_WIDTH; i++) begin : g_bits
        assign output_bits[i]    = out_q[i / 8][i % 8];
        assign direction_bits[i] = dir_q[i / 8][i % 8];
    end

    a_reset_clears : assert property (
        @(posedge BUS_CLK) RST |=> (output_bits == '0) && (direction_bits == '0)
    ) else $error("output or direction bits not cleared after reset");

endmodule : gpio_regs

//--- hdl/gpio_pads.sv
// pin stage with per-pin driver enable and output and a two-flop input synchronizer
`timescale 1ns/10ps

module gpio_pads #(
    parameter int unsigned         IO_WIDTH     = 8,
    parameter logic [IO_WIDTH-1:0] IO_DIRECTION = '0,
    parameter logic [IO_WIDTH-1:0] IO_TRI       = '0
) (
    input  logic                BUS_CLK,
    input  logic                RST,
    input  logic [IO_WIDTH-1:0] output_bits,
    input  logic [IO_WIDTH-1:0] direction_bits,
    input  logic [IO_WIDTH-1:0] io_i,
    output logic [IO_WIDTH-1:0] input_bits,
    output logic [IO_WIDTH-1:0] io_o,
    output logic [IO_WIDTH-1:0] io_oe
);

    logic [IO_WIDTH-1:0] sync_meta_q;
    logic [IO_WIDTH-1:0] sync_q;

    // pin kind picks the enable source
    for (genvar i = 0; i < IO_WIDTH; i++) begin : g_pin
        if (IO_TRI[i]) begin : g_tri
            assign io_oe[i] = direction_bits[i];
        end else if (IO_DIRECTION[i]) begin : g_out
            assign io_oe[i] = 1'b1;
        end else begin : g_in
            assign io_oe[i] = 1'b0;
        end
    end

    // output value only where the driver is on
    assign io_o = output_bits & io_oe;

    // pins are asynchronous to BUS_CLK
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            sync_meta_q <= '0;
            sync_q      <= '0;
        end else begin
            sync_meta_q <= io_i;
            sync_q      <= sync_meta_q;
        end
    end

    assign input_bits = sync_q;

    // input-only pins never drive whatever the registers hold
    a_no_drive_on_inputs : assert property (
        @(posedge BUS_CLK) (io_oe & ~(IO_DIRECTION | IO_TRI)) == '0
    ) else $error("driver enabled on an input-only pin");

endmodule : gpio_pads

//--- hdl/gpio_top.sv
// plain-port top level connecting decoder, register bank and pin stage
`timescale 1ns/10ps

module gpio_top #(
    parameter int unsigned          ABUSWIDTH    = 16,
    parameter logic [ABUSWIDTH-1:0] BASEADDR     = 16'h1000,
    parameter logic [ABUSWIDTH-1:0] HIGHADDR     = 16'h100F,
    parameter int unsigned          IO_WIDTH     = 12,
    // fixed output pins
    parameter logic [IO_WIDTH-1:0]  IO_DIRECTION = 12'h0F0,
    // tristate pins
    parameter logic [IO_WIDTH-1:0]  IO_TRI       = 12'hF00
) (
    input  logic                 BUS_CLK,
    input  logic                 RST,
    input  logic [ABUSWIDTH-1:0] bus_add,
    input  gpio_pkg::byte_t      bus_wdata,
    input  logic                 bus_rd,
    input  logic                 bus_wr,
    output gpio_pkg::byte_t      bus_rdata,
    input  logic [IO_WIDTH-1:0]  io_i,
    output logic [IO_WIDTH-1:0]  io_o,
    output logic [IO_WIDTH-1:0]  io_oe
);

    logic [IO_WIDTH-1:0] input_bits;
    logic [IO_WIDTH-1:0] output_bits;
    logic [IO_WIDTH-1:0] direction_bits;

    ip_bus_if #(.ABUSWIDTH(ABUSWIDTH)) ip_bus ();

    bus_to_ip #(
        .ABUSWIDTH (ABUSWIDTH),
        .BASEADDR  (BASEADDR),
        .HIGHADDR  (HIGHADDR)
    ) u_bus_to_ip (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_wdata    (bus_wdata),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .bus_rdata_ip (ip_bus.rdata),
        .bus_rdata    (bus_rdata),
        .ip           (ip_bus.decoder)
    );

    gpio_regs #(
        .IO_WIDTH (IO_WIDTH)
    ) u_gpio_regs (
        .BUS_CLK        (BUS_CLK),
        .RST            (RST),
        .input_bits     (input_bits),
        .output_bits    (output_bits),
        .direction_bits (direction_bits),
        .ip             (ip_bus.core)
    );

    gpio_pads #(
        .IO_WIDTH     (IO_WIDTH),
        .IO_DIRECTION (IO_DIRECTION),
        .IO_TRI       (IO_TRI)
    ) u_gpio_pads (
        .BUS_CLK        (BUS_CLK),
        .RST            (RST),
        .output_bits    (output_bits),
        .direction_bits (direction_bits),
        .io_i           (io_i),
        .input_bits     (input_bits),
        .io_o           (io_o),
        .io_oe          (io_oe)
    );

endmodule : gpio_top

//--- verification/tb_clock_gen.sv
// BUS_CLK generator and power-on reset for the testbench
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS  = 100,
    parameter int unsigned RST_CYCLES = 8
) (
    output logic BUS_CLK,
    output logic RST
);

    initial begin
        BUS_CLK = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            BUS_CLK = ~BUS_CLK;
        end
    end

    // released on a falling edge like the rest of the stimulus
    initial begin
        RST <= 1'b1;
        repeat (RST_CYCLES) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        RST <= 1'b0;
    end

endmodule : tb_clock_gen

//--- verification/gpio_tb.sv
// testbench top with random bus and pin stimulus, reference model, compare tasks and timeouts
`timescale 1ns/10ps

module gpio_tb;
    import gpio_pkg::*;

    localparam int unsigned         ABUSWIDTH    = 16;
    localparam logic [15:0]         BASEADDR     = 16'h1000;
    localparam logic [15:0]         HIGHADDR     = 16'h100F;
    localparam int unsigned         IO_WIDTH     = 12;
    localparam logic [IO_WIDTH-1:0] IO_DIRECTION = 12'h0F0;
    localparam logic [IO_WIDTH-1:0] IO_TRI       = 12'hF00;
    localparam int unsigned         io_bytes     = (IO_WIDTH + 7) / 8;
    localparam int unsigned         win_last     = 32'(HIGHADDR - BASEADDR);
    localparam int unsigned         rst_timeout  = 32;
    localparam int unsigned         run_timeout  = 5000;
    localparam int unsigned         rand_seed    = 32'hb80b_a232;

    logic                 BUS_CLK;
    logic                 RST;
    logic [ABUSWIDTH-1:0] bus_add;
    byte_t                bus_wdata;
    logic                 bus_rd;
    logic                 bus_wr;
    byte_t                bus_rdata;
    logic [IO_WIDTH-1:0]  io_i;
    logic [IO_WIDTH-1:0]  io_o;
    logic [IO_WIDTH-1:0]  io_oe;

    // model of the output and direction bytes and of the pin inputs
    byte_t               out_m [io_bytes];
    byte_t               dir_m [io_bytes];
    logic [IO_WIDTH-1:0] in_m;

    tb_clock_gen u_clock_gen (
        .BUS_CLK (BUS_CLK),
        .RST     (RST)
    );

    gpio_top #(
        .ABUSWIDTH    (ABUSWIDTH),
        .BASEADDR     (BASEADDR),
        .HIGHADDR     (HIGHADDR),
        .IO_WIDTH     (IO_WIDTH),
        .IO_DIRECTION (IO_DIRECTION),
        .IO_TRI       (IO_TRI)
    ) u_gpio_top (.*);

    // group of an offset and the byte index within it
    function automatic reg_sel_e classify_offset(input int unsigned off, output int unsigned idx);
        idx = 0;
        if (off == 0)
            return sel_version;
        if (off > 3 * io_bytes)
            return sel_none;
        idx = (off - 1) % io_bytes;
        if (off <= io_bytes)
            return sel_input;
        return (off <= 2 * io_bytes) ? sel_output : sel_direction;
    endfunction

    function automatic byte_t expected_read(input logic [15:0] addr);
        int unsigned           idx;
        reg_sel_e              sel;
        logic [io_bytes*8-1:0] in_wide;
        in_wide = '0;
        in_wide[IO_WIDTH-1:0] = in_m;
        if (addr < BASEADDR || addr > HIGHADDR)
            return '0;
        sel = classify_offset(32'(addr - BASEADDR), idx);
        case (sel)
            sel_version:   return GPIO_VERSION;
            sel_input:     return in_wide[idx*8 +: 8];
            sel_output:    return out_m[idx];
            sel_direction: return dir_m[idx];
            default:       return '0;
        endcase
    endfunction

    function automatic void model_write(input logic [15:0] addr, input byte_t data);
        int unsigned idx;
        reg_sel_e    sel;
        if (addr < BASEADDR || addr > HIGHADDR)
            return;
        sel = classify_offset(32'(addr - BASEADDR), idx);
        if (sel == sel_version) begin
            // soft reset
            foreach (out_m[b]) begin
                out_m[b] = '0;
                dir_m[b] = '0;
            end
        end else if (sel == sel_output) begin
            out_m[idx] = data;
        end else if (sel == sel_direction) begin
            dir_m[idx] = data;
        end
    endfunction

    function automatic logic [IO_WIDTH-1:0] model_bits(input bit want_dir);
        logic [IO_WIDTH-1:0] bits;
        for (int i = 0; i < IO_WIDTH; i++)
            bits[i] = want_dir ? dir_m[i / 8][i % 8] : out_m[i / 8][i % 8];
        return bits;
    endfunction

    // tristate pins follow their direction bit and fixed outputs always drive
    function automatic logic [IO_WIDTH-1:0] expected_oe();
        logic [IO_WIDTH-1:0] dir_bits;
        logic [IO_WIDTH-1:0] oe;
        dir_bits = model_bits(1'b1);
        for (int i = 0; i < IO_WIDTH; i++)
            oe[i] = IO_TRI[i] ? dir_bits[i] : IO_DIRECTION[i];
        return oe;
    endfunction

    // pin value by kind, zero on input pins and on disabled tristate pins
    function automatic logic [IO_WIDTH-1:0] expected_o();
        logic [IO_WIDTH-1:0] out_bits;
        logic [IO_WIDTH-1:0] dir_bits;
        logic [IO_WIDTH-1:0] o;
        out_bits = model_bits(1'b0);
        dir_bits = model_bits(1'b1);
        for (int i = 0; i < IO_WIDTH; i++) begin
            if (IO_TRI[i])
                o[i] = dir_bits[i] ? out_bits[i] : 1'b0;
            else if (IO_DIRECTION[i])
                o[i] = out_bits[i];
            else
                o[i] = 1'b0;
        end
        return o;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected)
            report_failure($sformatf("CHECK FAILED at %0t: %s expected 0x%02h, actual 0x%02h",
                                     $time, name, expected, actual));
    endtask

    task automatic check_pins(input string name, input logic [IO_WIDTH-1:0] expected,
                              input logic [IO_WIDTH-1:0] actual);
        if (actual !== expected)
            report_failure($sformatf("CHECK FAILED at %0t: %s expected 0x%03h, actual 0x%03h",
                                     $time, name, expected, actual));
    endtask

    task automatic check_pin_state();
        check_pins("io_oe", expected_oe(), io_oe);
        check_pins("io_o", expected_o(), io_o);
    endtask

    task automatic write_reg(input logic [15:0] addr, input byte_t data);
        @(negedge BUS_CLK);
        bus_add   = addr;
        bus_wdata = data;
        bus_wr    = 1'b1;
        @(negedge BUS_CLK);
        bus_wr = 1'b0;
        model_write(addr, data);
    endtask

    // read data is valid one cycle after the strobe
    task automatic read_and_check(input logic [15:0] addr);
        @(negedge BUS_CLK);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge BUS_CLK);
        bus_rd = 1'b0;
        check_byte($sformatf("bus_rdata[0x%04h]", addr), expected_read(addr), bus_rdata);
    endtask

    task automatic read_window();
        for (int unsigned k = 0; k <= win_last; k++)
            read_and_check(BASEADDR + 16'(k));
    endtask

    task automatic fill_regs();
        for (int unsigned k = io_bytes + 1; k <= 3 * io_bytes; k++)
            write_reg(BASEADDR + 16'(k), byte_t'($urandom));
    endtask

    // two sync stages plus margin before any read
    task automatic set_inputs(input logic [IO_WIDTH-1:0] value);
        @(negedge BUS_CLK);
        io_i = value;
        in_m = value;
        repeat (4) @(negedge BUS_CLK);
    endtask

    task automatic wait_reset_release();
        for (int unsigned c = 0; c < rst_timeout && RST !== 1'b0; c++)
            @(negedge BUS_CLK);
        if (RST !== 1'b0)
            report_failure("reset was not released within the timeout");
    endtask

    initial begin
        for (int unsigned c = 0; c < run_timeout; c++)
            @(posedge BUS_CLK);
        report_failure("run did not finish within the cycle limit");
    end

    initial begin
        logic [15:0] addr;
        bus_add   = '0;
        bus_wdata = '0;
        bus_rd    = 1'b0;
        bus_wr    = 1'b0;
        io_i      = '0;
        in_m      = '0;
        foreach (out_m[b]) begin
            out_m[b] = '0;
            dir_m[b] = '0;
        end
        void'($urandom(rand_seed));
        wait_reset_release();

        // reset state
        read_window();
        check_pin_state();

        // random writes with pin checks and random read-back
        repeat (60) begin
            addr = BASEADDR + 16'($urandom_range(3 * io_bytes, io_bytes + 1));
            write_reg(addr, byte_t'($urandom));
            check_pin_state();
            read_and_check(BASEADDR + 16'($urandom_range(win_last, 0)));
        end

        // input sampling
        repeat (8) begin
            set_inputs(IO_WIDTH'($urandom));
            for (int unsigned k = 1; k <= io_bytes; k++)
                read_and_check(BASEADDR + 16'(k));
        end

        // soft reset through offset 0
        repeat (3) begin
            fill_regs();
            write_reg(BASEADDR, byte_t'($urandom));
            check_pin_state();
            read_window();
        end

        // accesses outside the window and at unmapped or read-only offsets
        fill_regs();
        repeat (20) begin
            if ($urandom_range(1, 0) == 0)
                addr = 16'($urandom_range(32'(BASEADDR) - 1, 0));
            else
                addr = 16'($urandom_range(32'hFFFF, 32'(HIGHADDR) + 1));
            read_and_check(addr);
            write_reg(addr, byte_t'($urandom));
            if ($urandom_range(1, 0) == 0)
                addr = BASEADDR + 16'($urandom_range(io_bytes, 1));
            else
                addr = BASEADDR + 16'($urandom_range(win_last, 3 * io_bytes + 1));
            read_and_check(addr);
            write_reg(addr, byte_t'($urandom));
        end
        read_window();
        check_pin_state();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule : gpio_tb

//--- vlog.f
hdl/gpio_pkg.sv
hdl/ip_bus_if.sv
hdl/bus_to_ip.sv
hdl/gpio_regs.sv
hdl/gpio_pads.sv
hdl/gpio_top.sv
verification/tb_clock_gen.sv
verification/gpio_tb.sv

//--- Makefile
# verilator build and run of the gpio testbench
VERILATOR ?= verilator
TOP       ?= gpio_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
